/* src.f */
soc_pkg.sv
uart_pkg.sv
gpio_bank_if.sv
uart_rx.sv
cmd_decoder.sv
gpio_bank.sv
reply_tx.sv
azadi_soc_top.sv
tb_azadi_soc_top.sv

/* Bender.yml */
package:
  name: azadi_soc

sources:
  - files:
      - soc_pkg.sv
      - uart_pkg.sv
      - gpio_bank_if.sv
      - uart_rx.sv
      - cmd_decoder.sv
      - gpio_bank.sv
      - reply_tx.sv
      - azadi_soc_top.sv
  - target: test
    files:
      - tb_azadi_soc_top.sv

/* tb_azadi_soc_top.sv */
`default_nettype none

module tb_azadi_soc_top;

  localparam int BIT_T   = uart_pkg::CLKS_PER_BIT;
  localparam int FRAME_T = 10 * BIT_T;
  localparam int BW      = soc_pkg::BANK_W;

  logic                       clock_i;
  logic                       rst_i;
  logic [soc_pkg::GPIO_W-1:0] gpio_i;
  logic [soc_pkg::GPIO_W-1:0] gpio_o;
  logic                       uart_rx_i;
  logic                       uart_tx_o;

  // expected pin state built from the commands sent
  logic [soc_pkg::GPIO_W-1:0] gpio_model;

  integer                     seed;
  logic [31:0]                rnd;
  logic [2:0]                 bank;

  azadi_soc_top UUT (
    .clock_i   (clock_i),
    .rst_i     (rst_i),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
  );

  initial clock_i = 1'b0;
  always #10 clock_i = ~clock_i;

  task abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task report_mismatch(input string sig, input logic [31:0] exp_val, input logic [31:0] got_val);
    abort_run($sformatf("** Error: %s expected 0x%0h, got 0x%0h", sig, exp_val, got_val));
  endtask

  // host side 8N1 frame
  // starts on a falling edge
  task send_byte(input logic [7:0] b);
    uart_rx_i = 1'b0;
    repeat (BIT_T) @(negedge clock_i);
    for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
      uart_rx_i = b[i];
      repeat (BIT_T) @(negedge clock_i);
    end
    uart_rx_i = 1'b1;
    repeat (BIT_T) @(negedge clock_i);
  endtask

  // line must stay high for the whole window
  task watch_line_idle(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clock_i);
      assert (uart_tx_o === 1'b1) else report_mismatch("uart_tx_o", 32'h1, uart_tx_o);
    end
  endtask

  // one reply frame sampled mid bit
  task capture_reply(output logic [7:0] data);
    int n;
    n = 0;
    while (uart_tx_o !== 1'b0 && n < 3 * FRAME_T) begin
      @(negedge clock_i);
      n++;
    end
    if (uart_tx_o !== 1'b0) abort_run("no reply frame appeared on uart_tx_o");
    repeat (BIT_T / 2) @(negedge clock_i);
    assert (uart_tx_o === 1'b0) else report_mismatch("uart_tx_o start bit", 32'h0, uart_tx_o);
    for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
      repeat (BIT_T) @(negedge clock_i);
      data[i] = uart_tx_o;
    end
    repeat (BIT_T) @(negedge clock_i);
    assert (uart_tx_o === 1'b1) else report_mismatch("uart_tx_o stop bit", 32'h1, uart_tx_o);
  endtask

  // pins should already match
  // short settle allowed
  task check_gpio;
    int n;
    n = 0;
    while (gpio_o !== gpio_model && n < 8) begin
      @(negedge clock_i);
      n++;
    end
    assert (gpio_o === gpio_model) else report_mismatch("gpio_o", gpio_model, gpio_o);
  endtask

  // pad fills the ignored command bits 6..3
  task write_bank(input logic [2:0] idx, input logic [7:0] data, input logic [3:0] pad);
    send_byte({1'b1, pad, idx});
    send_byte(data);
    if (idx < 3'(soc_pkg::NUM_BANKS)) begin
      gpio_model[int'(idx) * BW +: BW] = data[BW-1:0];
    end
    check_gpio();
  endtask

  task read_bank(input logic [2:0] idx, input logic [3:0] pad);
    logic [7:0] reply;
    logic [7:0] expected;
    // output nibble on top and pad nibble below
    expected = {gpio_model[int'(idx) * BW +: BW], gpio_i[int'(idx) * BW +: BW]};
    fork
      send_byte({1'b0, pad, idx});
      capture_reply(reply);
    join
    assert (reply === expected) else report_mismatch("reply byte", expected, reply);
  endtask

  // command frame plus two more frame times of silence
  task read_unused(input logic [2:0] idx);
    fork
      send_byte({5'b0, idx});
      watch_line_idle(3 * FRAME_T);
    join
    check_gpio();
  endtask

  initial begin
    seed       = 71913;
    rst_i      = 1'b1;
    uart_rx_i  = 1'b1;
    gpio_i     = '0;
    gpio_model = '0;
    repeat (2) @(negedge clock_i);
    rst_i = 1'b0;

    // reset state
    assert (gpio_o === '0) else report_mismatch("gpio_o", 32'h0, gpio_o);
    watch_line_idle(4 * BIT_T);

    // one write per bank
    // upper data nibble is junk
    for (int k = 0; k < soc_pkg::NUM_BANKS; k++) begin
      write_bank(3'(k), {4'hF, 4'(k + 9)}, 4'(k));
    end

    // input nibbles differ from the output nibbles
    gpio_i = 20'h4E561;
    repeat (4) @(negedge clock_i);
    for (int k = 0; k < soc_pkg::NUM_BANKS; k++) begin
      read_bank(3'(k), 4'hA);
    end

    // indices 5..7 touch nothing
    // data byte looks like a read command for bank 2
    for (int k = soc_pkg::NUM_BANKS; k < 8; k++) begin
      write_bank(3'(k), 8'h02, 4'h0);
      read_unused(3'(k));
    end

    // random mix of writes and reads
    for (int n = 0; n < 30; n++) begin
      rnd    = $random(seed);
      gpio_i = rnd[soc_pkg::GPIO_W-1:0];
      rnd    = $random(seed);
      bank   = 3'(rnd[15:8] % soc_pkg::NUM_BANKS);
      // input synchronizer needs two cycles
      repeat (4) @(negedge clock_i);
      if (rnd[0]) begin
        write_bank(bank, rnd[31:24], rnd[4:1]);
      end else begin
        read_bank(bank, rnd[4:1]);
      end
    end

    assert (gpio_o === gpio_model) else report_mismatch("gpio_o", gpio_model, gpio_o);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* azadi_soc_top.sv */
`default_nettype none

module azadi_soc_top (
  input  wire logic                       clock_i,
  input  wire logic                       rst_i,
  input  wire logic [soc_pkg::GPIO_W-1:0] gpio_i,
  output logic      [soc_pkg::GPIO_W-1:0] gpio_o,
  input  wire logic                       uart_rx_i,
  output logic                            uart_tx_o
);

  // received byte stream
  logic       byte_valid;
  logic [7:0] byte_data;

  // readback request to the transmitter
  logic                      rd_stb;
  logic [soc_pkg::IDX_W-1:0] rd_idx;

  // one link per bank
  gpio_bank_if bank_if [soc_pkg::NUM_BANKS] ();

  uart_rx u_uart_rx (
    .clock_i      (clock_i),
    .rst_i        (rst_i),
    .rx_i         (uart_rx_i),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data)
  );

  cmd_decoder u_cmd_decoder (
    .clock_i      (clock_i),
    .rst_i        (rst_i),
    .byte_valid_i (byte_valid),
    .byte_data_i  (byte_data),
    .banks        (bank_if),
    .rd_stb_o     (rd_stb),
    .rd_idx_o     (rd_idx)
  );

  // bank k drives gpio bits 4k+3 down to 4k
  for (genvar g = 0; g < soc_pkg::NUM_BANKS; g++) begin : g_bank
    gpio_bank u_gpio_bank (
      .clock_i (clock_i),
      .rst_i   (rst_i),
      .bus     (bank_if[g]),
      .pad_i   (gpio_i[g*soc_pkg::BANK_W +: soc_pkg::BANK_W]),
      .pad_o   (gpio_o[g*soc_pkg::BANK_W +: soc_pkg::BANK_W])
    );
  end

  reply_tx u_reply_tx (
    .clock_i  (clock_i),
    .rst_i    (rst_i),
    .banks    (bank_if),
    .rd_stb_i (rd_stb),
    .rd_idx_i (rd_idx),
    .tx_o     (uart_tx_o)
  );

endmodule

`default_nettype wire

/* reply_tx.sv */
`default_nettype none

module reply_tx (
  input  wire logic                      clock_i,
  input  wire logic                      rst_i,
  gpio_bank_if.mon                       banks [soc_pkg::NUM_BANKS],
  input  wire logic                      rd_stb_i,
  input  wire logic [soc_pkg::IDX_W-1:0] rd_idx_i,
  output logic                           tx_o
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  tx_state_e state_q;

  // reply byte per bank, output nibble on top
  logic [7:0] bank_word [soc_pkg::NUM_BANKS];

  logic [uart_pkg::CNT_W-1:0]     cnt_q;
  logic [uart_pkg::BIT_IDX_W-1:0] bit_idx_q;
  logic [7:0]                     shreg_q;
  logic                           bit_end;

  // interface arrays need constant indices
  for (genvar g = 0; g < soc_pkg::NUM_BANKS; g++) begin : g_mon
    assign bank_word[g] = {banks[g].out_state, banks[g].in_state};
  end

  assign bit_end = (cnt_q == uart_pkg::CNT_W'(uart_pkg::CLKS_PER_BIT - 1));

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_o      <= 1'b1;
    end else begin
      cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          cnt_q <= '0;
          // requests while busy are simply lost
          if (rd_stb_i) begin
            tx_o    <= 1'b0;
            state_q <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            tx_o      <= shreg_q[0];
            bit_idx_q <= '0;
            state_q   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == uart_pkg::BIT_IDX_W'(uart_pkg::DATA_BITS - 1)) begin
              tx_o    <= 1'b1;
              state_q <= TX_STOP;
            end else begin
              tx_o <= shreg_q[0];
            end
          end
        end
        TX_STOP: begin
          // full stop bit before going idle
          if (bit_end) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // frame payload, shifted out lsb first
  always_ff @(posedge clock_i) begin
    if (state_q == TX_IDLE && rd_stb_i) begin
      shreg_q <= bank_word[rd_idx_i];
    end else if (bit_end && (state_q == TX_START || state_q == TX_DATA)) begin
      shreg_q <= {1'b0, shreg_q[7:1]};
    end
  end

endmodule

`default_nettype wire

/* gpio_bank.sv */
`default_nettype none

module gpio_bank (
  input  wire logic                       clock_i,
  input  wire logic                       rst_i,
  gpio_bank_if.bank                       bus,
  input  wire logic [soc_pkg::BANK_W-1:0] pad_i,
  output logic      [soc_pkg::BANK_W-1:0] pad_o
);

  // output nibble register
  logic [soc_pkg::BANK_W-1:0] out_q;

  // input synchronizer stages
  logic [soc_pkg::BANK_W-1:0] sync0_q;
  logic [soc_pkg::BANK_W-1:0] sync1_q;

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      out_q <= '0;
    end else if (bus.wr_stb) begin
      // pins follow one cycle after the strobe
      out_q <= bus.wdata;
    end
  end

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      sync0_q <= '0;
      sync1_q <= '0;
    end else begin
      // pad inputs are asynchronous to clock_i
      sync0_q <= pad_i;
      sync1_q <= sync0_q;
    end
  end

  assign pad_o = out_q;

  // state seen by the reply path
  assign bus.out_state = out_q;
  // two cycles behind the pads
  assign bus.in_state  = sync1_q;

endmodule

`default_nettype wire

/* cmd_decoder.sv */
`default_nettype none

module cmd_decoder (
  input  wire logic                     clock_i,
  input  wire logic                     rst_i,
  input  wire logic                     byte_valid_i,
  input  wire logic [7:0]               byte_data_i,
  gpio_bank_if.ctrl                     banks [soc_pkg::NUM_BANKS],
  output logic                          rd_stb_o,
  output logic [soc_pkg::IDX_W-1:0]     rd_idx_o
);

  typedef enum logic {
    WAIT_CMD,
    WAIT_DATA
  } dec_state_e;

  dec_state_e state_q;

  // index field of the incoming byte
  logic [soc_pkg::IDX_W-1:0] cmd_idx;
  logic                      cmd_idx_ok;
  // write target held across the data byte
  logic [soc_pkg::IDX_W-1:0] pend_idx_q;

  logic [soc_pkg::NUM_BANKS-1:0] wr_stb_q;
  logic [soc_pkg::BANK_W-1:0]    wdata_q;

  assign cmd_idx    = byte_data_i[soc_pkg::CMD_IDX_LSB +: soc_pkg::IDX_W];
  assign cmd_idx_ok = (cmd_idx < soc_pkg::IDX_W'(soc_pkg::NUM_BANKS));

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      state_q    <= WAIT_CMD;
      pend_idx_q <= '0;
      wr_stb_q   <= '0;
      rd_stb_o   <= 1'b0;
      rd_idx_o   <= '0;
    end else begin
      wr_stb_q <= '0;
      rd_stb_o <= 1'b0;
      if (byte_valid_i) begin
        case (state_q)
          WAIT_CMD: begin
            if (byte_data_i[soc_pkg::CMD_WR_BIT]) begin
              // bad index still eats the data byte
              pend_idx_q <= cmd_idx;
              state_q    <= WAIT_DATA;
            end else if (cmd_idx_ok) begin
              rd_stb_o <= 1'b1;
              rd_idx_o <= cmd_idx;
            end
          end
          WAIT_DATA: begin
            // one-hot strobe, nothing for index 5..7
            for (int i = 0; i < soc_pkg::NUM_BANKS; i++) begin
              wr_stb_q[i] <= (pend_idx_q == soc_pkg::IDX_W'(i));
            end
            state_q <= WAIT_CMD;
          end
          default: state_q <= WAIT_CMD;
        endcase
      end
    end
  end

  // low nibble of the data byte, shared by all banks
  always_ff @(posedge clock_i) begin
    if (byte_valid_i && state_q == WAIT_DATA) begin
      wdata_q <= byte_data_i[soc_pkg::BANK_W-1:0];
    end
  end

  for (genvar g = 0; g < soc_pkg::NUM_BANKS; g++) begin : g_ctrl
    assign banks[g].wr_stb = wr_stb_q[g];
    assign banks[g].wdata  = wdata_q;
  end

endmodule

`default_nettype wire

/* uart_rx.sv */
`default_nettype none

module uart_rx (
  input  wire logic       clock_i,
  input  wire logic       rst_i,
  input  wire logic       rx_i,
  output logic            byte_valid_o,
  output logic [7:0]      byte_data_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e state_q;

  // two-flop synchronizer plus one more for edge detect
  logic [1:0] rx_sync_q;
  logic       rx_prev_q;
  logic       rx_s;

  logic [uart_pkg::CNT_W-1:0]     cnt_q;
  logic [uart_pkg::BIT_IDX_W-1:0] bit_idx_q;
  logic [7:0]                     shreg_q;

  assign rx_s = rx_sync_q[1];

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      // line idles high
      rx_sync_q <= 2'b11;
      rx_prev_q <= 1'b1;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
      rx_prev_q <= rx_s;
    end
  end

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      state_q      <= RX_IDLE;
      cnt_q        <= '0;
      bit_idx_q    <= '0;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      cnt_q        <= cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          // falling edge marks a start bit
          if (rx_prev_q && !rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // middle of start bit, glitch check
          if (cnt_q == uart_pkg::CNT_W'(uart_pkg::HALF_BIT - 1)) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          // one full bit later lands mid data bit
          if (cnt_q == uart_pkg::CNT_W'(uart_pkg::CLKS_PER_BIT - 1)) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == uart_pkg::BIT_IDX_W'(uart_pkg::DATA_BITS - 1)) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (cnt_q == uart_pkg::CNT_W'(uart_pkg::CLKS_PER_BIT - 1)) begin
            cnt_q        <= '0;
            // low stop bit means framing error, drop it
            byte_valid_o <= rx_s;
            state_q      <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // data shift register, lsb arrives first
  always_ff @(posedge clock_i) begin
    if (state_q == RX_DATA &&
        cnt_q == uart_pkg::CNT_W'(uart_pkg::CLKS_PER_BIT - 1)) begin
      shreg_q <= {rx_s, shreg_q[7:1]};
    end
  end

  assign byte_data_o = shreg_q;

endmodule

`default_nettype wire

/* gpio_bank_if.sv */
`default_nettype none

interface gpio_bank_if;

  // one-cycle write pulse from the decoder
  logic                      wr_stb;
  // new output nibble, valid with wr_stb
  logic [soc_pkg::BANK_W-1:0] wdata;
  // current output register
  logic [soc_pkg::BANK_W-1:0] out_state;
  // input pins after the synchronizer
  logic [soc_pkg::BANK_W-1:0] in_state;

  // decoder side
  modport ctrl (output wr_stb, output wdata);

  // bank side
  modport bank (input wr_stb, input wdata, output out_state, output in_state);

  // reply transmitter side, read only
  modport mon (input out_state, input in_state);

endinterface

`default_nettype wire

/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // clocks per serial bit, short for simulation
  localparam int CLKS_PER_BIT = 16;

  // half a bit, used to find the middle of the start bit
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  // data bits per 8N1 frame, lsb first
  localparam int DATA_BITS = 8;

  // counter widths
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_IDX_W = $clog2(DATA_BITS);

endpackage

`default_nettype wire

/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // gpio map for the peripheral subsystem
  // five banks of four pins each

  // number of gpio banks
  localparam int NUM_BANKS = 5;

  // pins per bank
  localparam int BANK_W = 4;

  // full gpio width at the top level
  localparam int GPIO_W = NUM_BANKS * BANK_W;

  // bank index field in the command byte
  // wide enough for 0..7, only 0..4 are real banks
  localparam int IDX_W = 3;

  // index field starts at bit 0
  localparam int CMD_IDX_LSB = 0;

  // write flag, high means a data byte follows
  // low means readback request
  localparam int CMD_WR_BIT = 7;

  // command byte layout
  //   [7]   write flag
  //   [6:3] ignored
  //   [2:0] bank index
  // readback reply layout
  //   [7:4] output nibble
  //   [3:0] synchronized input nibble

endpackage

`default_nettype wire
